// File: rtl/ppu_timing_consts.svh
// Picture processor scan timing constants
`ifndef PPU_TIMING_CONSTS_SVH
`define PPU_TIMING_CONSTS_SVH

// Frame geometry
`define PPU_H_TOTAL          341
`define PPU_V_TOTAL          262
`define PPU_H_VISIBLE        256
`define PPU_V_VISIBLE        240

// Horizontal decode positions, end values are exclusive
`define PPU_HSYNC_START      280
`define PPU_HSYNC_END        305
`define PPU_BURST_START      309
`define PPU_BURST_END        324
`define PPU_PREFETCH_START   320
`define PPU_PREFETCH_END     336

// Vertical decode positions
`define PPU_VSET_LINE        241
`define PPU_VCLR_LINE        261
`define PPU_EVENT_DOT        1
`define PPU_VSYNC_START      244
`define PPU_VSYNC_END        247

// CPU register map
`define PPU_REG_CTRL         0
`define PPU_REG_STATUS       1
`define PPU_CTRL_VBL_EN_BIT  7
`define PPU_CTRL_RENDER_BIT  3
`define PPU_STATUS_VBL_BIT   7

`endif

// File: rtl/ppu_timing_pkg.sv
// Scan timing shared types
`default_nettype none

package ppu_timing_pkg;

	// Current scan position
	typedef struct packed {
		logic [8:0] h;      // Dot within the line
		logic [8:0] v;      // Line within the frame
	} pos_t;

	// Horizontal timing strobes
	typedef struct packed {
		logic hblank;
		logic hsync;
		logic burst;        // Color burst window
		logic sc_cnt;       // Scroll counter update
	} hsig_t;

	// Background fetch phases
	typedef struct packed {
		logic f_nt;         // Name table
		logic f_at;         // Attribute table
		logic f_ta;         // Tile low plane
		logic f_tb;         // Tile high plane
	} fetch_t;

	// Vertical timing, vset and vclr are single-cycle events
	typedef struct packed {
		logic picture;
		logic vblank;
		logic vsync;
		logic blnk;
		logic vset;
		logic vclr;
	} vsig_t;

	// Wishbone classic request from the CPU side
	typedef struct packed {
		logic       cyc;
		logic       stb;
		logic       we;
		logic       adr;
		logic [7:0] dat;
	} wb_req_t;

	// Wishbone classic response
	typedef struct packed {
		logic       ack;
		logic [7:0] dat;
	} wb_rsp_t;

endpackage

`default_nettype wire

// File: rtl/hv_counter_ctrl.sv
// Dot and line counters
`default_nettype none
`timescale 1ns/1ps
`include "ppu_timing_consts.svh"

module hv_counter_ctrl (
	input  wire                    pclk,
	input  wire                    arst_n,
	output ppu_timing_pkg::pos_t   pos
);

	logic line_end;     // Last dot of a line
	logic frame_end;    // Last dot of the pre-render line

	// Wrap points of both counters
	assign line_end  = (pos.h == 9'(`PPU_H_TOTAL - 1));
	assign frame_end = line_end && (pos.v == 9'(`PPU_V_TOTAL - 1));

	// The dot counter runs every cycle, the line counter steps at each line wrap
	always_ff @(posedge pclk or negedge arst_n) begin
		if (!arst_n) begin
			pos <= '0;
		end else begin
			if (line_end) begin
				pos.h <= '0;
			end else begin
				pos.h <= pos.h + 9'd1;
			end

			if (frame_end) begin
				pos.v <= '0;            // Back to the first visible line
			end else if (line_end) begin
				pos.v <= pos.v + 9'd1;
			end
		end
	end

endmodule

`default_nettype wire

// File: rtl/hpos_logic.sv
// Horizontal position decoder
`default_nettype none
`timescale 1ns/1ps
`include "ppu_timing_consts.svh"

module hpos_logic (
	input  wire                      pclk,
	input  wire                      arst_n,
	input  ppu_timing_pkg::pos_t     pos,
	input  wire                      render_en,
	output ppu_timing_pkg::hsig_t    hsig,
	output ppu_timing_pkg::fetch_t   fetch
);

	logic                     in_window;  // Visible fetch or next-line prefetch
	logic [2:0]               phase;      // Dot within the 8-dot fetch group
	ppu_timing_pkg::hsig_t    hsig_d;
	ppu_timing_pkg::fetch_t   fetch_d;

	assign phase = pos.h[2:0];

	assign in_window = (pos.h < 9'(`PPU_H_VISIBLE)) ||
		((pos.h >= 9'(`PPU_PREFETCH_START)) && (pos.h < 9'(`PPU_PREFETCH_END)));

	// Range decode of the dot number
	always_comb begin
		hsig_d.hblank = (pos.h >= 9'(`PPU_H_VISIBLE));
		hsig_d.hsync  = (pos.h >= 9'(`PPU_HSYNC_START)) && (pos.h < 9'(`PPU_HSYNC_END));
		hsig_d.burst  = (pos.h >= 9'(`PPU_BURST_START)) && (pos.h < 9'(`PPU_BURST_END));
		hsig_d.sc_cnt = hsig_d.hblank & render_en;   // Scroll update only while rendering
	end

	// Each fetch takes two dots, the strobe marks the second one
	always_comb begin
		fetch_d = '0;
		if (in_window && render_en) begin
			case (phase)
				3'd1: fetch_d.f_nt = 1'b1;
				3'd3: fetch_d.f_at = 1'b1;
				3'd5: fetch_d.f_ta = 1'b1;
				3'd7: fetch_d.f_tb = 1'b1;
				default: fetch_d = '0;
			endcase
		end
	end

	// One cycle behind pos so every strobe switches on the same edge
	always_ff @(posedge pclk or negedge arst_n) begin
		if (!arst_n) begin
			hsig  <= '0;
			fetch <= '0;
		end else begin
			hsig  <= hsig_d;
			fetch <= fetch_d;
		end
	end

endmodule

`default_nettype wire

// File: rtl/vpos_logic.sv
// Vertical position decoder
`default_nettype none
`timescale 1ns/1ps
`include "ppu_timing_consts.svh"

module vpos_logic (
	input  wire                     pclk,
	input  wire                     arst_n,
	input  ppu_timing_pkg::pos_t    pos,
	input  wire                     render_en,
	output ppu_timing_pkg::vsig_t   vsig
);

	logic                    event_dot;  // Dot where the flag events fire
	ppu_timing_pkg::vsig_t   vsig_d;

	assign event_dot = (pos.h == 9'(`PPU_EVENT_DOT));

	always_comb begin
		vsig_d.picture = (pos.v < 9'(`PPU_V_VISIBLE));
		vsig_d.vblank  = (pos.v >= 9'(`PPU_VSET_LINE)) && (pos.v < 9'(`PPU_VCLR_LINE));
		vsig_d.vsync   = (pos.v >= 9'(`PPU_VSYNC_START)) && (pos.v < 9'(`PPU_VSYNC_END));
		vsig_d.blnk    = vsig_d.vblank | ~render_en;  // Black out when rendering is off

		// Single-dot events, once per frame each
		vsig_d.vset = event_dot && (pos.v == 9'(`PPU_VSET_LINE));
		vsig_d.vclr = event_dot && (pos.v == 9'(`PPU_VCLR_LINE));
	end

	// Same one-cycle latency as the horizontal decode
	always_ff @(posedge pclk or negedge arst_n) begin
		if (!arst_n) begin
			vsig <= '0;
		end else begin
			vsig <= vsig_d;
		end
	end

endmodule

`default_nettype wire

// File: rtl/vblank_int.sv
// VBlank flag, interrupt and CPU registers
`default_nettype none
`timescale 1ns/1ps
`include "ppu_timing_consts.svh"

module vblank_int (
	input  wire                       pclk,
	input  wire                       arst_n,
	input  ppu_timing_pkg::wb_req_t   wb_req,
	output ppu_timing_pkg::wb_rsp_t   wb_rsp,
	input  wire                       vset,
	input  wire                       vclr,
	output logic                      render_en,
	output logic                      irq
);

	logic [7:0] ctrl;         // Control register
	logic       vbl_flag;
	logic       ack;
	logic [7:0] rd_dat;       // Read data held during ack
	logic [7:0] rd_next;
	logic       req;          // New transfer this cycle
	logic       wr_ctrl;
	logic       rd_status;

	// A request is taken once; ack high blocks the held strobe
	assign req       = wb_req.cyc & wb_req.stb & ~ack;
	assign wr_ctrl   = req & wb_req.we & (wb_req.adr == 1'(`PPU_REG_CTRL));
	assign rd_status = req & ~wb_req.we & (wb_req.adr == 1'(`PPU_REG_STATUS));

	// Read mux, a status read racing vset sees the flag still clear
	always_comb begin
		rd_next = '0;
		if (wb_req.adr == 1'(`PPU_REG_STATUS)) begin
			rd_next[`PPU_STATUS_VBL_BIT] = vbl_flag & ~vset;
		end else begin
			rd_next = ctrl;
		end
	end

	// Handshake and control register
	always_ff @(posedge pclk or negedge arst_n) begin
		if (!arst_n) begin
			ack  <= 1'b0;
			ctrl <= '0;
		end else begin
			ack <= req;                 // Exactly one cycle per transfer
			if (wr_ctrl) begin
				ctrl <= wb_req.dat;
			end
		end
	end

	// Set wins over both clears
	always_ff @(posedge pclk or negedge arst_n) begin
		if (!arst_n) begin
			vbl_flag <= 1'b0;
		end else if (vset) begin
			vbl_flag <= 1'b1;
		end else if (vclr || rd_status) begin
			vbl_flag <= 1'b0;
		end
	end

	always_ff @(posedge pclk) begin
		if (req) begin
			rd_dat <= rd_next;
		end
	end

	assign wb_rsp.ack = ack;
	assign wb_rsp.dat = rd_dat;

	assign render_en = ctrl[`PPU_CTRL_RENDER_BIT];
	assign irq       = vbl_flag & ctrl[`PPU_CTRL_VBL_EN_BIT];   // Both from registers

endmodule

`default_nettype wire

// File: rtl/ppu_fsm.sv
// Picture processor scan timing core
`default_nettype none
`timescale 1ns/1ps

module ppu_fsm (
	input  wire                       pclk,
	input  wire                       arst_n,
	input  ppu_timing_pkg::wb_req_t   wb_req,
	output ppu_timing_pkg::wb_rsp_t   wb_rsp,
	output ppu_timing_pkg::pos_t      pos,
	output ppu_timing_pkg::hsig_t     hsig,
	output ppu_timing_pkg::fetch_t    fetch,
	output ppu_timing_pkg::vsig_t     vsig,
	output logic                      irq
);

	logic render_en;    // From the control register

	hv_counter_ctrl u_hv_ctrl (
		.pclk   (pclk),
		.arst_n (arst_n),
		.pos    (pos)
	);

	hpos_logic u_hpos (
		.pclk      (pclk),
		.arst_n    (arst_n),
		.pos       (pos),
		.render_en (render_en),
		.hsig      (hsig),
		.fetch     (fetch)
	);

	vpos_logic u_vpos (
		.pclk      (pclk),
		.arst_n    (arst_n),
		.pos       (pos),
		.render_en (render_en),
		.vsig      (vsig)
	);

	vblank_int u_vbl (
		.pclk      (pclk),
		.arst_n    (arst_n),
		.wb_req    (wb_req),
		.wb_rsp    (wb_rsp),
		.vset      (vsig.vset),
		.vclr      (vsig.vclr),
		.render_en (render_en),
		.irq       (irq)
	);

endmodule

`default_nettype wire

// File: test/tb_ppu_checks.svh
// Timing reference model and compare tasks
`ifndef TB_PPU_CHECKS_SVH
`define TB_PPU_CHECKS_SVH

function automatic ppu_timing_pkg::pos_t next_pos(input ppu_timing_pkg::pos_t p);
	ppu_timing_pkg::pos_t n;
	int h;
	int v;
	h = int'(p.h) + 1;
	v = int'(p.v);
	if (h == `PPU_H_TOTAL) begin
		h = 0;
		v = (v + 1) % `PPU_V_TOTAL;   // Frame wrap after the pre-render line
	end
	n.h = 9'(h);
	n.v = 9'(v);
	return n;
endfunction

function automatic ppu_timing_pkg::hsig_t exp_hsig(input ppu_timing_pkg::pos_t p, input logic ren);
	ppu_timing_pkg::hsig_t e;
	int h;
	h = int'(p.h);
	e.hblank = (h >= `PPU_H_VISIBLE);
	e.hsync  = (h >= `PPU_HSYNC_START) && (h < `PPU_HSYNC_END);
	e.burst  = (h >= `PPU_BURST_START) && (h < `PPU_BURST_END);
	e.sc_cnt = e.hblank && ren;
	return e;
endfunction

function automatic ppu_timing_pkg::fetch_t exp_fetch(input ppu_timing_pkg::pos_t p, input logic ren);
	ppu_timing_pkg::fetch_t e;
	int h;
	int ph;
	logic win;
	h = int'(p.h);
	ph = h % 8;
	win = (h < `PPU_H_VISIBLE) || ((h >= `PPU_PREFETCH_START) && (h < `PPU_PREFETCH_END));
	e = '0;
	if (win && ren) begin
		e.f_nt = (ph == 1);
		e.f_at = (ph == 3);
		e.f_ta = (ph == 5);
		e.f_tb = (ph == 7);
	end
	return e;
endfunction

function automatic ppu_timing_pkg::vsig_t exp_vsig(input ppu_timing_pkg::pos_t p, input logic ren);
	ppu_timing_pkg::vsig_t e;
	int h;
	int v;
	h = int'(p.h);
	v = int'(p.v);
	e.picture = (v < `PPU_V_VISIBLE);
	e.vblank  = (v >= `PPU_VSET_LINE) && (v < `PPU_VCLR_LINE);
	e.vsync   = (v >= `PPU_VSYNC_START) && (v < `PPU_VSYNC_END);
	e.blnk    = e.vblank || !ren;
	e.vset    = (v == `PPU_VSET_LINE) && (h == `PPU_EVENT_DOT);
	e.vclr    = (v == `PPU_VCLR_LINE) && (h == `PPU_EVENT_DOT);
	return e;
endfunction

task automatic abort_run(input string why);
	$display("=== FAIL ===");
	$fatal(1, "%s", why);
endtask

task automatic check_pos(input ppu_timing_pkg::pos_t exp, input ppu_timing_pkg::pos_t act);
	if (act !== exp) begin
		$display("Fail %0t pos expected %h got %h", $time, exp, act);
		abort_run("position counter mismatch");
	end
endtask

task automatic check_hsig(input ppu_timing_pkg::hsig_t exp, input ppu_timing_pkg::hsig_t act);
	if (act !== exp) begin
		$display("Fail %0t hsig expected %b got %b", $time, exp, act);
		abort_run("horizontal decode mismatch");
	end
endtask

task automatic check_fetch(input ppu_timing_pkg::fetch_t exp, input ppu_timing_pkg::fetch_t act);
	if (act !== exp) begin
		$display("Fail %0t fetch expected %b got %b", $time, exp, act);
		abort_run("fetch phase mismatch");
	end
endtask

task automatic check_vsig(input ppu_timing_pkg::vsig_t exp, input ppu_timing_pkg::vsig_t act);
	if (act !== exp) begin
		$display("Fail %0t vsig expected %b got %b", $time, exp, act);
		abort_run("vertical decode mismatch");
	end
endtask

// Data only compared when cmp_dat is set
task automatic check_wb(input ppu_timing_pkg::wb_rsp_t exp, input ppu_timing_pkg::wb_rsp_t act,
	input logic cmp_dat);
	if ((act.ack !== exp.ack) || (cmp_dat && (act.dat !== exp.dat))) begin
		$display("Fail %0t wb_rsp expected %h got %h", $time, exp, act);
		abort_run("register port response mismatch");
	end
endtask

task automatic check_irq(input logic exp, input logic act);
	if (act !== exp) begin
		$display("Fail %0t irq expected %b got %b", $time, exp, act);
		abort_run("interrupt level mismatch");
	end
endtask

`endif

// File: test/tb_ppu_fsm.sv
// Scan timing core testbench
`default_nettype none
`timescale 1ns/1ps
`include "ppu_timing_consts.svh"

module tb_ppu_fsm;

	localparam int FRAME = `PPU_H_TOTAL * `PPU_V_TOTAL;
	// The interrupt test ends just after the vclr of the third frame
	localparam int LIMIT = 3 * FRAME + 1000;

	logic                     pclk;
	logic                     arst_n;
	ppu_timing_pkg::wb_req_t  wb_req;
	ppu_timing_pkg::wb_rsp_t  wb_rsp;
	ppu_timing_pkg::pos_t     pos;
	ppu_timing_pkg::hsig_t    hsig;
	ppu_timing_pkg::fetch_t   fetch;
	ppu_timing_pkg::vsig_t    vsig;
	logic                     irq;

	logic [31:0]              lfsr;
	logic [7:0]               ctrl_shadow;  // Last control value written
	logic                     pos_chk_en;
	ppu_timing_pkg::pos_t     pos_exp;
	int                       cycles = 0;

	`include "tb_ppu_checks.svh"

	ppu_fsm dut (
		.pclk   (pclk),
		.arst_n (arst_n),
		.wb_req (wb_req),
		.wb_rsp (wb_rsp),
		.pos    (pos),
		.hsig   (hsig),
		.fetch  (fetch),
		.vsig   (vsig),
		.irq    (irq)
	);

	initial begin
		pclk = 1'b0;
		forever #10 pclk = ~pclk;
	end

	always @(posedge pclk) begin
		cycles <= cycles + 1;
		if (cycles > LIMIT) begin
			$display("=== FAIL ===");
			$fatal(1, "Run limit of %0d cycles reached", LIMIT);
		end
	end

	// Counter rule checked on every cycle after reset
	always @(negedge pclk) begin
		if (!pos_chk_en) begin
			pos_exp = '0;
		end else begin
			check_pos(pos_exp, pos);
			pos_exp = next_pos(pos_exp);
		end
	end

	// Taps 32, 22, 2, 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic rand_bits(input int n, output logic [31:0] val);
		val = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_step(lfsr);
			val = {val[30:0], lfsr[0]};
		end
	endtask

	// Single transfer with ack due exactly one cycle after the request
	task automatic wb_transfer(input logic we, input logic adr, input logic [7:0] wdat,
		input logic [7:0] exp_dat, input logic cmp_dat);
		ppu_timing_pkg::wb_req_t r;
		ppu_timing_pkg::wb_rsp_t e;
		r.cyc = 1'b1;
		r.stb = 1'b1;
		r.we  = we;
		r.adr = adr;
		r.dat = wdat;
		e.ack = 1'b1;
		e.dat = exp_dat;
		@(posedge pclk);
		wb_req <= r;
		@(negedge pclk);
		if (wb_rsp.ack !== 1'b0)
			abort_run("ack came in the same cycle as the request");
		@(negedge pclk);
		check_wb(e, wb_rsp, cmp_dat);
		@(posedge pclk);
		wb_req <= '0;
		@(negedge pclk);
		if (wb_rsp.ack !== 1'b0)
			abort_run("ack stayed high for more than one cycle");
	endtask

	task automatic wb_write(input logic adr, input logic [7:0] wdat);
		wb_transfer(1'b1, adr, wdat, 8'h00, 1'b0);
		if (adr == 1'(`PPU_REG_CTRL))
			ctrl_shadow = wdat;
	endtask

	task automatic wb_read(input logic adr, input logic [7:0] exp_dat);
		wb_transfer(1'b0, adr, 8'h00, exp_dat, 1'b1);
	endtask

	// Each output sample is compared with the model of the position one cycle earlier
	task automatic check_decode_run(input int n, output int n_vset, output int n_vclr);
		ppu_timing_pkg::pos_t prev;
		logic ren;
		n_vset = 0;
		n_vclr = 0;
		ren = ctrl_shadow[`PPU_CTRL_RENDER_BIT];
		@(negedge pclk);
		prev = pos;
		for (int i = 0; i < n; i++) begin
			@(negedge pclk);
			check_hsig(exp_hsig(prev, ren), hsig);
			check_fetch(exp_fetch(prev, ren), fetch);
			check_vsig(exp_vsig(prev, ren), vsig);
			if (vsig.vset)
				n_vset++;
			if (vsig.vclr)
				n_vclr++;
			prev = pos;
		end
	endtask

	task automatic wait_event(input logic want_set);
		@(negedge pclk);
		while ((want_set ? vsig.vset : vsig.vclr) !== 1'b1)
			@(negedge pclk);
	endtask

	task automatic test_reset();
		repeat (7) @(posedge pclk);
		@(negedge pclk);
		check_pos('0, pos);
		check_hsig('0, hsig);
		check_fetch('0, fetch);
		check_vsig('0, vsig);
		check_irq(1'b0, irq);
		check_wb('0, wb_rsp, 1'b0);
		@(posedge pclk);
		arst_n <= 1'b1;
		pos_chk_en = 1'b1;
	endtask

	task automatic test_hdecode();
		logic [31:0] r;
		int target;
		int nv;
		int nc;
		wb_write(1'(`PPU_REG_CTRL), 8'h08);      // Rendering on
		check_decode_run(`PPU_H_TOTAL + 1, nv, nc);
		for (int k = 0; k < 8; k++) begin
			rand_bits(9, r);
			target = (int'(r[8:0]) + `PPU_H_TOTAL - 1) % `PPU_H_TOTAL;
			@(negedge pclk);
			while (int'(pos.h) != target)
				@(negedge pclk);
			check_decode_run(1, nv, nc);
		end
		wb_write(1'(`PPU_REG_CTRL), 8'h00);      // No fetches or scroll strobes now
		check_decode_run(`PPU_H_TOTAL + 1, nv, nc);
	endtask

	task automatic test_vdecode();
		int nv;
		int nc;
		wb_write(1'(`PPU_REG_CTRL), 8'h08);
		check_decode_run(FRAME, nv, nc);
		if ((nv != 1) || (nc != 1))
			abort_run($sformatf("frame held %0d vset and %0d vclr events", nv, nc));
	endtask

	task automatic test_regs();
		logic [31:0] r;
		rand_bits(8, r);
		wb_write(1'(`PPU_REG_CTRL), r[7:0]);
		wb_read(1'(`PPU_REG_CTRL), r[7:0]);
	endtask

	task automatic test_vblank_irq();
		logic [7:0] c;
		logic [7:0] stat_set;
		c = '0;
		c[`PPU_CTRL_VBL_EN_BIT] = 1'b1;
		c[`PPU_CTRL_RENDER_BIT] = 1'b1;
		stat_set = '0;
		stat_set[`PPU_STATUS_VBL_BIT] = 1'b1;
		wb_write(1'(`PPU_REG_CTRL), c);
		wb_transfer(1'b0, 1'(`PPU_REG_STATUS), 8'h00, 8'h00, 1'b0);  // Clears a stale flag
		wait_event(1'b1);
		check_irq(1'b0, irq);
		@(negedge pclk);
		check_irq(1'b1, irq);
		wb_read(1'(`PPU_REG_STATUS), stat_set);
		check_irq(1'b0, irq);
		wb_read(1'(`PPU_REG_STATUS), 8'h00);
		// Next frame stays unread until vclr
		wait_event(1'b1);
		@(negedge pclk);
		check_irq(1'b1, irq);
		wait_event(1'b0);
		@(negedge pclk);
		check_irq(1'b0, irq);
		wb_read(1'(`PPU_REG_STATUS), 8'h00);
	endtask

	initial begin
		arst_n <= 1'b0;
		wb_req <= '0;
		lfsr = 32'hddc50da6;
		ctrl_shadow = '0;
		pos_chk_en = 1'b0;
		test_reset();
		test_hdecode();
		test_vdecode();
		test_regs();
		test_vblank_irq();
		$display("=== PASS ===");
		$finish;
	end

endmodule

`default_nettype wire

// File: sources.f
+incdir+rtl
+incdir+test
rtl/ppu_timing_pkg.sv
rtl/hv_counter_ctrl.sv
rtl/hpos_logic.sv
rtl/vpos_logic.sv
rtl/vblank_int.sv
rtl/ppu_fsm.sv
test/tb_ppu_fsm.sv

// File: run.sh
#!/bin/sh
# Builds the scan timing testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"
verilator --binary --timing -j 0 --top-module tb_ppu_fsm -f sources.f \
	-Mdir obj_dir -o tb_ppu_fsm
./obj_dir/tb_ppu_fsm
